// ==== src/filter_pkg.sv ====
`default_nettype none

package filter_pkg;

	// Width of one packet word as it arrives on the input stream
	localparam int DATA_WIDTH = 64;

	// Widest packet-memory address any lane may be built with
	localparam int MAX_ADDR_WIDTH = 10;

	// One packet-memory write, as it travels from ingest through dispatch to a lane
	typedef struct packed {
		logic [MAX_ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0]     data;
		logic                      wr_en;
		// Pulses once in the cycle after the last word of a packet
		logic                      done;
	} mem_wr_t;

	// Layout of the first word of every packet
	typedef struct packed {
		logic [15:0] proto;
		// Total word count, the header word included
		logic [15:0] length;
		// XOR over the low 32 bits of all payload words
		logic [31:0] checksum;
	} pkt_hdr_t;

	// Word 0 is decoded as a header, every later word as plain data
	typedef union packed {
		logic [DATA_WIDTH-1:0] raw;
		pkt_hdr_t              hdr;
	} pkt_word_u;

	// Result of filtering one packet
	typedef struct packed {
		logic        accept;
		// Number of words actually received
		logic [15:0] length;
	} verdict_t;

endpackage

`default_nettype wire

// ==== src/packet_ingest.sv ====
`default_nettype none

module packet_ingest #(
	parameter int ADDR_WIDTH = 6
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              in_valid,
	input  logic [filter_pkg::DATA_WIDTH-1:0] in_data,
	input  logic                              in_last,
	output logic                              in_ready,
	input  logic                              mem_ready,
	output filter_pkg::mem_wr_t               wr
);

	// Word address inside the current packet
	logic [ADDR_WIDTH-1:0] addr_cnt;
	// Registered end-of-packet marker, drives the done strobe
	logic                  done_q;
	logic                  take;

	// Hold the stream off in the done cycle, the dispatcher may swap lanes right after it
	assign in_ready = mem_ready && !done_q;
	assign take     = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			addr_cnt <= '0;
			done_q   <= 1'b0;
		end else begin
			done_q <= take && in_last;
			if (take) begin
				// Last word wraps the counter so the next packet starts at zero
				if (in_last)
					addr_cnt <= '0;
				else
					addr_cnt <= addr_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		wr                       = '0;
		wr.addr[ADDR_WIDTH-1:0]  = addr_cnt;
		wr.data                  = in_data;
		wr.wr_en                 = take;
		wr.done                  = done_q;
	end

	// A packet longer than the lane memory would wrap over its own header
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		!(in_valid && (&addr_cnt) && !in_last));

endmodule

`default_nettype wire

// ==== src/lane_dispatch.sv ====
`default_nettype none

module lane_dispatch #(
	parameter int NUM_LANES = 4,
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                                clk,
	input  logic                                reset,
	input  filter_pkg::mem_wr_t                 wr,
	output logic                                mem_ready,
	input  logic [NUM_LANES-1:0]                lane_ready,
	output filter_pkg::mem_wr_t [NUM_LANES-1:0] lane_wr,
	output logic                                choice_valid,
	output logic [LANE_W-1:0]                   choice_idx
);

	// High at a packet boundary, and kept high while no lane is free
	logic              reselect;
	logic [LANE_W-1:0] choice_saved;
	logic [LANE_W-1:0] choice;
	logic [LANE_W-1:0] pick;
	logic              found;

	// Lowest-index ready lane wins, so walk downward and let later hits overwrite
	always_comb begin
		pick  = '0;
		found = 1'b0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (lane_ready[i]) begin
				pick  = LANE_W'(i);
				found = 1'b1;
			end
		end
	end

	// The choice may only move at a boundary, otherwise the saved one stands
	assign choice = (reselect && found) ? pick : choice_saved;

	always_ff @(posedge clk) begin
		if (reset) begin
			// Start out searching so the first packet lands in the lowest free lane
			reselect     <= 1'b1;
			choice_saved <= '0;
		end else begin
			reselect     <= wr.done || (reselect && !found);
			choice_saved <= choice;
		end
	end

	// While nothing is free the saved lane is busy too, so ready stays low
	assign mem_ready = lane_ready[choice];

	// Address and data fan out to all lanes, only the strobes are steered
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_wr[i]       = wr;
			lane_wr[i].wr_en = wr.wr_en && (choice == LANE_W'(i));
			lane_wr[i].done  = wr.done && (choice == LANE_W'(i));
		end
	end

	// The merge block learns which lane got the packet when it closes
	assign choice_valid = wr.done;
	assign choice_idx   = choice;

	a_wr_needs_ready: assert property (@(posedge clk) disable iff (reset)
		wr.wr_en |-> mem_ready);

endmodule

`default_nettype wire

// ==== src/filter_lane.sv ====
`default_nettype none

module filter_lane #(
	parameter int          ADDR_WIDTH   = 6,
	parameter logic [15:0] ACCEPT_PROTO = 16'h0800
) (
	input  logic                 clk,
	input  logic                 reset,
	input  filter_pkg::mem_wr_t  wr,
	output logic                 lane_ready,
	output logic                 verdict_ready,
	output filter_pkg::verdict_t lane_verdict,
	input  logic                 take
);
	import filter_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_SCAN, ST_HOLD} state_t;

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	state_t                state;
	logic [DATA_WIDTH-1:0] mem [DEPTH];
	// Counts need one extra bit, a full memory holds DEPTH words
	logic [ADDR_WIDTH:0]   wr_cnt;
	logic [ADDR_WIDTH:0]   issue_ptr;
	logic                  issue;
	// Read stage, one word behind the issue pointer
	logic                  rd_valid;
	logic [ADDR_WIDTH:0]   rd_idx;
	pkt_word_u             rd_word;
	logic                  rd_last;
	// Running header and checksum, plus their values with the current word folded in
	pkt_hdr_t              hdr_q;
	logic [31:0]           csum_q;
	pkt_hdr_t              cur_hdr;
	logic [31:0]           cur_csum;
	logic                  accept;

	assign lane_ready    = (state == ST_IDLE);
	assign verdict_ready = (state == ST_HOLD);
	assign issue         = (state == ST_SCAN) && (issue_ptr < wr_cnt);

	// Packet storage, written only while the lane is waiting for a packet
	always_ff @(posedge clk) begin
		if (wr.wr_en && state == ST_IDLE)
			mem[wr.addr[ADDR_WIDTH-1:0]] <= wr.data;
	end

	// Synchronous read, one word per scan cycle
	always_ff @(posedge clk) begin
		if (issue) begin
			rd_word.raw <= mem[issue_ptr[ADDR_WIDTH-1:0]];
			rd_idx      <= issue_ptr;
		end
	end

	// Word 0 goes through the header view, the rest only feed the checksum
	always_comb begin
		cur_hdr  = (rd_idx == '0) ? rd_word.hdr : hdr_q;
		cur_csum = (rd_idx == '0) ? 32'h0 : (csum_q ^ rd_word.raw[31:0]);
		rd_last  = rd_valid && (rd_idx == wr_cnt - 1'b1);
		accept   = (cur_hdr.proto == ACCEPT_PROTO) &&
			(cur_hdr.length == 16'(wr_cnt)) &&
			(cur_hdr.checksum == cur_csum);
	end

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			hdr_q  <= cur_hdr;
			csum_q <= cur_csum;
		end
		// Verdict is latched with the last word and held until taken
		if (rd_last) begin
			lane_verdict.accept <= accept;
			lane_verdict.length <= 16'(wr_cnt);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			wr_cnt    <= '0;
			issue_ptr <= '0;
			rd_valid  <= 1'b0;
		end else begin
			rd_valid <= issue;
			case (state)
				ST_IDLE: begin
					if (wr.wr_en)
						wr_cnt <= wr_cnt + 1'b1;
					if (wr.done) begin
						state     <= ST_SCAN;
						issue_ptr <= '0;
					end
				end
				ST_SCAN: begin
					if (issue)
						issue_ptr <= issue_ptr + 1'b1;
					if (rd_last)
						state <= ST_HOLD;
				end
				ST_HOLD: begin
					// Free again once the merge block has collected the verdict
					if (take) begin
						state  <= ST_IDLE;
						wr_cnt <= '0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_addr_fits: assert property (@(posedge clk) ADDR_WIDTH <= MAX_ADDR_WIDTH);

	// Dispatch must never steer words into a lane that is still scanning or holding
	a_wr_idle_only: assert property (@(posedge clk) disable iff (reset)
		wr.wr_en |-> state == ST_IDLE);

endmodule

`default_nettype wire

// ==== src/verdict_merge.sv ====
`default_nettype none

module verdict_merge #(
	parameter int NUM_LANES = 4,
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 choice_valid,
	input  logic [LANE_W-1:0]                    choice_idx,
	input  logic [NUM_LANES-1:0]                 verdict_ready,
	input  filter_pkg::verdict_t [NUM_LANES-1:0] lane_verdict,
	output logic [NUM_LANES-1:0]                 take,
	output logic                                 verdict_valid,
	output filter_pkg::verdict_t                 verdict
);

	// Lane indices in the order their packets arrived
	logic [LANE_W-1:0] fifo [NUM_LANES];
	logic [LANE_W-1:0] wr_ptr;
	logic [LANE_W-1:0] rd_ptr;
	logic [LANE_W:0]   count;
	logic [LANE_W-1:0] head;
	logic              pop;

	assign head = fifo[rd_ptr];
	// Only the oldest packet may leave, even if later lanes are done already
	assign pop  = (count != '0) && verdict_ready[head];

	always_ff @(posedge clk) begin
		if (choice_valid)
			fifo[wr_ptr] <= choice_idx;
		if (pop)
			verdict <= lane_verdict[head];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			take          <= '0;
			verdict_valid <= 1'b0;
		end else begin
			if (choice_valid)
				wr_ptr <= (wr_ptr == LANE_W'(NUM_LANES - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LANE_W'(NUM_LANES - 1)) ? '0 : rd_ptr + 1'b1;
			case ({choice_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Release the head lane in the same cycle its verdict goes out
			verdict_valid <= pop;
			take          <= '0;
			if (pop)
				take[head] <= 1'b1;
		end
	end

	// Each lane holds one packet at most, so the queue cannot run over
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		!(choice_valid && count == (LANE_W + 1)'(NUM_LANES)));

endmodule

`default_nettype wire

// ==== src/packet_filter_top.sv ====
`default_nettype none

module packet_filter_top #(
	parameter int          NUM_LANES    = 4,
	parameter int          ADDR_WIDTH   = 6,
	parameter logic [15:0] ACCEPT_PROTO = 16'h0800
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              in_valid,
	input  logic [filter_pkg::DATA_WIDTH-1:0] in_data,
	input  logic                              in_last,
	output logic                              in_ready,
	output logic                              verdict_valid,
	output filter_pkg::verdict_t              verdict
);
	import filter_pkg::*;

	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	mem_wr_t                    wr;
	logic                       mem_ready;
	mem_wr_t  [NUM_LANES-1:0]   lane_wr;
	logic     [NUM_LANES-1:0]   lane_ready;
	logic                       choice_valid;
	logic     [LANE_W-1:0]      choice_idx;
	logic     [NUM_LANES-1:0]   verdict_ready;
	verdict_t [NUM_LANES-1:0]   lane_verdict;
	logic     [NUM_LANES-1:0]   take;

	packet_ingest #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_packet_ingest (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_data  (in_data),
		.in_last  (in_last),
		.in_ready (in_ready),
		.mem_ready(mem_ready),
		.wr       (wr)
	);

	lane_dispatch #(
		.NUM_LANES(NUM_LANES)
	) i_lane_dispatch (
		.clk         (clk),
		.reset       (reset),
		.wr          (wr),
		.mem_ready   (mem_ready),
		.lane_ready  (lane_ready),
		.lane_wr     (lane_wr),
		.choice_valid(choice_valid),
		.choice_idx  (choice_idx)
	);

	// One filter per lane, all identical
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		filter_lane #(
			.ADDR_WIDTH  (ADDR_WIDTH),
			.ACCEPT_PROTO(ACCEPT_PROTO)
		) i_filter_lane (
			.clk          (clk),
			.reset        (reset),
			.wr           (lane_wr[g]),
			.lane_ready   (lane_ready[g]),
			.verdict_ready(verdict_ready[g]),
			.lane_verdict (lane_verdict[g]),
			.take         (take[g])
		);
	end

	verdict_merge #(
		.NUM_LANES(NUM_LANES)
	) i_verdict_merge (
		.clk          (clk),
		.reset        (reset),
		.choice_valid (choice_valid),
		.choice_idx   (choice_idx),
		.verdict_ready(verdict_ready),
		.lane_verdict (lane_verdict),
		.take         (take),
		.verdict_valid(verdict_valid),
		.verdict      (verdict)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	// Free-running clock with an even duty cycle
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset drops on a rising edge, the same way every other input changes
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb/packet_filter_tb.sv ====
`default_nettype none

module packet_filter_tb;
	import filter_pkg::*;

	localparam int          NUM_LANES    = 4;
	localparam int          ADDR_WIDTH   = 6;
	localparam logic [15:0] ACCEPT_PROTO = 16'h0800;
	// Extra cycles on top of the per-packet allowance
	localparam int          MARGIN       = 200;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic [DATA_WIDTH-1:0] in_data;
	logic                  in_last;
	logic                  in_ready;
	logic                  verdict_valid;
	verdict_t              verdict;

	// Stimulus table, one entry per packet in send order
	string       row_name[$];
	logic [15:0] row_proto[$];
	int          row_decl[$];
	int          row_len[$];
	bit          row_corrupt[$];
	int          row_gap[$];

	// Verdicts the DUT owes us, oldest first
	verdict_t exp_q[$];
	string    exp_name[$];
	verdict_t exp_v;
	string    exp_n;

	logic [31:0]           lcg_state;
	// Words of the packet being sent, sized like one lane memory
	logic [DATA_WIDTH-1:0] words[2 ** ADDR_WIDTH];
	int                    limit_cycles = 0;
	int                    stall_run;
	int                    max_stall;

	tb_clock #(
		.PERIOD      (40),
		.RESET_CYCLES(2)
	) i_tb_clock (
		.clk  (clk),
		.reset(reset)
	);

	packet_filter_top #(
		.NUM_LANES   (NUM_LANES),
		.ADDR_WIDTH  (ADDR_WIDTH),
		.ACCEPT_PROTO(ACCEPT_PROTO)
	) i_packet_filter_top (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_data      (in_data),
		.in_last      (in_last),
		.in_ready     (in_ready),
		.verdict_valid(verdict_valid),
		.verdict      (verdict)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Two LCG steps fill one payload word
	task automatic random_word(output logic [DATA_WIDTH-1:0] w);
		lcg_state = lcg_step(lcg_state);
		w[63:32]  = lcg_state;
		lcg_state = lcg_step(lcg_state);
		w[31:0]   = lcg_state;
	endtask

	task automatic add_row(input string name, input logic [15:0] proto, input int decl,
		input int len, input bit corrupt, input int gap);
		row_name.push_back(name);
		row_proto.push_back(proto);
		row_decl.push_back(decl);
		row_len.push_back(len);
		row_corrupt.push_back(corrupt);
		row_gap.push_back(gap);
	endtask

	task automatic fill_table();
		add_row("good_short",   16'h0800, 5, 5, 1'b0, 2);
		add_row("bad_proto",    16'h86dd, 5, 5, 1'b0, 2);
		add_row("bad_checksum", 16'h0800, 7, 7, 1'b1, 2);
		// Header claims two words more than are sent
		add_row("bad_length",   16'h0800, 8, 6, 1'b0, 3);
		add_row("header_only",  16'h0800, 1, 1, 1'b0, 1);
		// Short packets overtake the long one in their lanes, yet must come out after it
		add_row("long_first",   16'h0800, 50, 50, 1'b0, 0);
		add_row("short_a",      16'h0800, 3, 3, 1'b0, 0);
		add_row("short_b",      16'h86dd, 3, 3, 1'b0, 0);
		add_row("short_c",      16'h0800, 3, 3, 1'b0, 0);
		add_row("short_d",      16'h0800, 4, 4, 1'b0, 0);
		add_row("short_e",      16'h0800, 2, 2, 1'b0, 6);
		// More long packets than lanes, back to back
		for (int b = 0; b < NUM_LANES + 2; b++)
			add_row($sformatf("burst_%0d", b), 16'h0800, 40, 40, b == 3, 0);
	endtask

	// Fills words[] for one row and works out the verdict from the accept rule
	task automatic build_packet(input int i, output verdict_t v);
		logic [31:0] csum;
		pkt_hdr_t    hdr;
		csum = '0;
		for (int k = 1; k < row_len[i]; k++) begin
			random_word(words[k]);
			csum ^= words[k][31:0];
		end
		hdr.proto    = row_proto[i];
		hdr.length   = 16'(row_decl[i]);
		hdr.checksum = row_corrupt[i] ? ~csum : csum;
		words[0]     = hdr;
		v.accept     = (row_proto[i] == ACCEPT_PROTO) && (row_decl[i] == row_len[i]) &&
			!row_corrupt[i];
		v.length     = 16'(row_len[i]);
	endtask

	// Holds one word on the bus until the DUT takes it, returns on that rising edge
	task automatic send_word(input logic [DATA_WIDTH-1:0] w, input logic last);
		logic taken;
		in_valid <= 1'b1;
		in_data  <= w;
		in_last  <= last;
		stall_run = 0;
		do begin
			@(negedge clk);
			taken = in_ready;
			if (!taken) begin
				stall_run++;
				if (stall_run > max_stall)
					max_stall = stall_run;
			end
			@(posedge clk);
		end while (!taken);
	endtask

	task automatic check_verdict(input string name, input verdict_t expected,
		input verdict_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected accept=%0b length=%0d, actual accept=%0b length=%0d",
				name, expected.accept, expected.length, actual.accept, actual.length);
			$display("*** FAILED ***");
			$fatal(1, "verdict mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %0b, actual %0b", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Each verdict_valid pulse is matched against the oldest packet still owed
	always @(negedge clk) begin
		if (!reset && verdict_valid) begin
			if (exp_q.size() == 0) begin
				$display("A verdict came out although every packet was already answered");
				$display("*** FAILED ***");
				$fatal(1, "unexpected verdict");
			end else begin
				exp_v = exp_q.pop_front();
				exp_n = exp_name.pop_front();
				check_verdict(exp_n, exp_v, verdict);
			end
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Run timed out after %0d cycles waiting for verdicts, %0d still missing",
			limit_cycles, exp_q.size());
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		verdict_t v;
		in_valid  <= 1'b0;
		in_data   <= '0;
		in_last   <= 1'b0;
		lcg_state = 32'd69521;
		max_stall = 0;
		fill_table();
		// Worst case every packet waits behind a full set of lanes
		for (int i = 0; i < row_name.size(); i++)
			limit_cycles += (row_len[i] + 4) * NUM_LANES + row_gap[i];
		limit_cycles += MARGIN;
		do begin
			@(negedge clk);
		end while (reset);
		@(posedge clk);
		for (int i = 0; i < row_name.size(); i++) begin
			build_packet(i, v);
			exp_q.push_back(v);
			exp_name.push_back(row_name[i]);
			for (int k = 0; k < row_len[i]; k++)
				send_word(words[k], k == row_len[i] - 1);
			if (row_gap[i] > 0) begin
				in_valid <= 1'b0;
				in_last  <= 1'b0;
				repeat (row_gap[i]) @(posedge clk);
			end
		end
		in_valid <= 1'b0;
		in_last  <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		// Give a stray extra verdict time to show up
		repeat (4 * NUM_LANES) @(posedge clk);
		// A boundary alone stalls one cycle, only full lanes stall longer
		check_flag("in_ready_backpressure", 1'b1, max_stall > 2);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/filter_pkg.sv
src/packet_ingest.sv
src/lane_dispatch.sv
src/filter_lane.sv
src/verdict_merge.sv
src/packet_filter_top.sv
tb/tb_clock.sv
tb/packet_filter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the packet filter testbench with Verilator and runs it.
# A failing check ends in $fatal, so the simulator's exit status is the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module packet_filter_tb \
	--Mdir obj_dir \
	-f verilog.f
./obj_dir/Vpacket_filter_tb
